//--- logic/aluCluster_macros.svh
// ==========================================================================
// ALU cluster widths, shared by the package, the RTL and the testbench
// ==========================================================================

`ifndef ALUCLUSTER_MACROS_SVH
`define ALUCLUSTER_MACROS_SVH

// Operand and result width of every datapath in the cluster
`define DATA_WIDTH 64

// Width of a reorder-buffer tag carried alongside each operation
`define ROB_INDEX_BITS 5

// Multiplier bits retired on every iteration of the shift-add loop
`define MUL_STEP_BITS 4

// Iterations needed to walk the whole multiplier operand
`define MUL_ITERS (`DATA_WIDTH / `MUL_STEP_BITS)

// One mask bit per byte of the datapath
`define BYTE_LANES (`DATA_WIDTH / 8)

`endif

//--- logic/aluClusterPkg.sv
// ==========================================================================
// ALU cluster types for operands, tags, byte masks and the decode bus
// ==========================================================================

`include "aluCluster_macros.svh"

package aluClusterPkg;

	// One register-file operand or one execute result
	typedef logic [`DATA_WIDTH-1:0] value_t;

	// Reorder-buffer tag that follows the instruction to writeback
	typedef logic [`ROB_INDEX_BITS-1:0] robIndex_t;

	// Per-byte mask, bit n covers bits 8n+7 down to 8n of a value
	typedef logic [`BYTE_LANES-1:0] laneMask_t;

	// Arithmetic operations handled by the cluster
	// MUL is the only one that goes to the multicycle unit
	typedef enum logic [2:0] {
		ADD  = 3'd0,
		AND  = 3'd1,
		OR   = 3'd2,
		XOR  = 3'd3,
		MUL  = 3'd4,
		PASS = 3'd5
	} aluOp_e;

	// Decoded fields that come with an issued instruction
	typedef struct packed {
		// Operation to perform
		aluOp_e op;
		// Selects inversion instead of two's-complement negation
		logic bitwise;
		// Operand negate requests for A and B
		logic negA;
		logic negB;
		// Replace operand B by the immediate
		logic useImm;
		value_t imm;
		// Predicate bits, a zero keeps the old target byte
		laneMask_t predBits;
		// Instruction only copies its old target through
		logic copyTarget;
	} decodeBus_t;

endpackage

//--- logic/aluStationIf.sv
// ==========================================================================
// Loaded operation from the ALU station to the execute units and merge
// ==========================================================================

interface aluStationIf;
	import aluClusterPkg::*;

	// One-cycle strobe, the fields below are valid while it is high
	logic ld;
	// Reorder-buffer tag of the loaded operation
	robIndex_t id;
	// Operation after copy-target forcing
	aluOp_e op;
	// Final arguments and the old target value
	value_t argA;
	value_t argB;
	value_t argT;
	// Bytes that take the old target instead of the result
	laneMask_t cptgt;
	// Completion class of the loaded operation
	logic scDone;
	logic startMulti;

	// The station owns every signal
	modport station (output ld, id, op, argA, argB, argT, cptgt, scDone, startMulti);

	// Both execute units see the arguments and completion class
	modport execute (input ld, op, argA, argB, scDone, startMulti);

	// The merge only keeps what it needs to rebuild the target
	modport merge (input ld, id, argT, cptgt);

endinterface

//--- logic/aluStation.sv
// ==========================================================================
// ALU reservation station, captures an issued instruction and forms the
// final arguments, the copy-target byte mask and the completion class
// ==========================================================================

module aluStation (
	input logic clk,
	input logic rst,
	input logic available,
	input logic issue,
	input logic robIndexValid,
	input aluClusterPkg::robIndex_t robIndex,
	input aluClusterPkg::decodeBus_t decode,
	input aluClusterPkg::value_t rfArgA,
	input aluClusterPkg::value_t rfArgB,
	input aluClusterPkg::value_t rfArgT,
	input logic mulBusy,
	aluStationIf.station stage
);
	import aluClusterPkg::*;

	// Applies an operand's negate request
	// Bitwise operations want the ones' complement, arithmetic wants -x
	function automatic value_t formArg(input value_t raw, input logic neg,
			input logic bitwise);
		value_t result;
		if (!neg)
			result = raw;
		else if (bitwise)
			result = ~raw;
		else
			result = -raw;
		return result;
	endfunction

	logic accept;
	value_t nextArgA;
	value_t nextArgB;
	laneMask_t nextCptgt;
	logic copyOnly;
	logic singleCycle;

	// ======================================================================
	// Issue acceptance
	// ======================================================================

	// Nothing is queued here, a refused issue has to be presented again
	// The multiplier only raises mulBusy the cycle after the MUL is loaded,
	// so the station also holds off while its own startMulti is showing
	always_comb begin
		accept = available && issue && robIndexValid && !mulBusy && !stage.startMulti;
	end

	// ======================================================================
	// Argument and mask forming
	// ======================================================================

	always_comb begin
		nextArgA = formArg(rfArgA, decode.negA, decode.bitwise);
		// The immediate takes the place of B and is used as decoded
		if (decode.useImm)
			nextArgB = decode.imm;
		else
			nextArgB = formArg(rfArgB, decode.negB, decode.bitwise);
		// A set mask bit keeps the old target byte
		if (decode.copyTarget)
			nextCptgt = '1;
		else
			nextCptgt = ~decode.predBits;
		// With every byte kept the result is argT whatever the op was
		copyOnly = &nextCptgt;
		// Only a real MUL needs the multicycle unit
		singleCycle = (decode.op != MUL) || copyOnly;
	end

	// Control strobes, all low out of reset
	always_ff @(posedge clk) begin
		if (rst) begin
			stage.ld <= 1'b0;
			stage.scDone <= 1'b0;
			stage.startMulti <= 1'b0;
		end else begin
			stage.ld <= accept;
			stage.scDone <= accept && singleCycle;
			stage.startMulti <= accept && !singleCycle;
		end
	end

	// Loaded operation, only meaningful while ld is high
	always_ff @(posedge clk) begin
		if (accept) begin
			stage.id <= robIndex;
			// A copy-target goes down the plain pass path of the single-cycle unit
			stage.op <= copyOnly ? PASS : decode.op;
			stage.argA <= nextArgA;
			stage.argB <= nextArgB;
			stage.argT <= rfArgT;
			stage.cptgt <= nextCptgt;
		end
	end

endmodule

//--- logic/aluOperate.sv
// ==========================================================================
// Single-cycle ALU unit for add and bitwise operations, registered result
// ==========================================================================

module aluOperate (
	input logic clk,
	input logic rst,
	aluStationIf.execute stage,
	output logic opValid,
	output aluClusterPkg::value_t opResult
);
	import aluClusterPkg::*;

	logic start;
	value_t nextResult;

	// Only operations the station marked single-cycle come here
	always_comb begin
		start = stage.ld && stage.scDone;
	end

	// Negation and immediate selection already happened in the station
	always_comb begin
		case (stage.op)
			ADD:
				nextResult = stage.argA + stage.argB;
			AND:
				nextResult = stage.argA & stage.argB;
			OR:
				nextResult = stage.argA | stage.argB;
			XOR:
				nextResult = stage.argA ^ stage.argB;
			// PASS returns A, the merge then swaps in target bytes
			default:
				nextResult = stage.argA;
		endcase
	end

	// Valid strobe follows ld by exactly one cycle
	always_ff @(posedge clk) begin
		if (rst) begin
			opValid <= 1'b0;
		end else begin
			opValid <= start;
		end
	end

	// Result holds until the next single-cycle operation
	always_ff @(posedge clk) begin
		if (start) begin
			opResult <= nextResult;
		end
	end

endmodule

//--- logic/aluMultiplier.sv
// ==========================================================================
// Iterative shift-add multiplier, several multiplier bits per cycle, low
// half of the product kept
// ==========================================================================

`include "aluCluster_macros.svh"

module aluMultiplier (
	input logic clk,
	input logic rst,
	aluStationIf.execute stage,
	output logic mulBusy,
	output logic mulValid,
	output aluClusterPkg::value_t mulResult
);
	import aluClusterPkg::*;

	logic [$clog2(`MUL_ITERS)-1:0] count;
	logic drain;
	logic start;
	value_t multiplicand;
	value_t multiplier;
	value_t accum;
	value_t partial;
	logic [`MUL_STEP_BITS-1:0] digit;

	always_comb begin
		start = stage.ld && stage.startMulti;
		// Low digit of the remaining multiplier selects this step's multiple
		digit = multiplier[`MUL_STEP_BITS-1:0];
		// Only the low DATA_WIDTH bits of the product are ever needed
		partial = multiplicand * value_t'(digit);
	end

	// ======================================================================
	// Iteration control
	// ======================================================================

	// Busy covers exactly MUL_ITERS iterations after the load cycle
	// Drain marks the cycle after the last step, which raises mulValid
	always_ff @(posedge clk) begin
		if (rst) begin
			mulBusy <= 1'b0;
			drain <= 1'b0;
			mulValid <= 1'b0;
			count <= '0;
		end else begin
			mulValid <= drain;
			drain <= 1'b0;
			if (start) begin
				mulBusy <= 1'b1;
				count <= $bits(count)'(`MUL_ITERS - 1);
			end else if (mulBusy) begin
				count <= count - 1'b1;
				if (count == '0) begin
					mulBusy <= 1'b0;
					drain <= 1'b1;
				end
			end
		end
	end

	// ======================================================================
	// Datapath
	// ======================================================================

	// Multiplicand walks left and multiplier walks right one digit per step
	always_ff @(posedge clk) begin
		if (start) begin
			multiplicand <= stage.argA;
			multiplier <= stage.argB;
			accum <= '0;
		end else if (mulBusy) begin
			accum <= accum + partial;
			multiplicand <= multiplicand << `MUL_STEP_BITS;
			multiplier <= multiplier >> `MUL_STEP_BITS;
		end
	end

	// Accumulator is stable from the last step until the next MUL loads
	assign mulResult = accum;

endmodule

//--- logic/resultMerge.sv
// ==========================================================================
// Writeback merge, picks the finishing unit and restores kept target bytes
// ==========================================================================

`include "aluCluster_macros.svh"

module resultMerge (
	input logic clk,
	input logic rst,
	aluStationIf.merge stage,
	input logic opValid,
	input logic mulValid,
	input aluClusterPkg::value_t opResult,
	input aluClusterPkg::value_t mulResult,
	output logic wbValid,
	output aluClusterPkg::robIndex_t wbId,
	output aluClusterPkg::value_t wbValue
);
	import aluClusterPkg::*;

	// Two-entry record, a new single-cycle op loads while the last one retires
	robIndex_t idMem [0:1];
	value_t targetMem [0:1];
	laneMask_t maskMem [0:1];
	logic wrPtr;
	logic rdPtr;
	value_t finishValue;

	// Record every loaded operation, both units complete in issue order
	always_ff @(posedge clk) begin
		if (stage.ld) begin
			idMem[wrPtr] <= stage.id;
			targetMem[wrPtr] <= stage.argT;
			maskMem[wrPtr] <= stage.cptgt;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wrPtr <= 1'b0;
			rdPtr <= 1'b0;
		end else begin
			if (stage.ld)
				wrPtr <= ~wrPtr;
			if (wbValid)
				rdPtr <= ~rdPtr;
		end
	end

	// ======================================================================
	// Byte merge
	// ======================================================================

	// Idle blocks issue during a MUL so only one unit finishes per cycle
	always_comb begin
		wbValid = opValid || mulValid;
		finishValue = mulValid ? mulResult : opResult;
		wbId = idMem[rdPtr];
		for (int lane = 0; lane < `BYTE_LANES; lane++) begin
			if (maskMem[rdPtr][lane])
				wbValue[lane*8 +: 8] = targetMem[rdPtr][lane*8 +: 8];
			else
				wbValue[lane*8 +: 8] = finishValue[lane*8 +: 8];
		end
	end

endmodule

//--- logic/aluCluster.sv
// ==========================================================================
// ALU cluster top, station feeding the single-cycle unit, the multiplier
// and the writeback merge
// ==========================================================================

module aluCluster (
	input logic clk,
	input logic rst,
	input logic available,
	input logic issue,
	input logic robIndexValid,
	input aluClusterPkg::robIndex_t robIndex,
	input aluClusterPkg::decodeBus_t decode,
	input aluClusterPkg::value_t rfArgA,
	input aluClusterPkg::value_t rfArgB,
	input aluClusterPkg::value_t rfArgT,
	output logic idle,
	output logic wbValid,
	output aluClusterPkg::robIndex_t wbId,
	output aluClusterPkg::value_t wbValue
);
	import aluClusterPkg::*;

	logic mulBusy;
	logic opValid;
	logic mulValid;
	value_t opResult;
	value_t mulResult;

	// Loaded operation shared by the station, both units and the merge
	aluStationIf stage ();

	// The multiplier is the only unit that can hold off issue
	assign idle = ~mulBusy;

	aluStation station_i (
		.clk(clk),
		.rst(rst),
		.available(available),
		.issue(issue),
		.robIndexValid(robIndexValid),
		.robIndex(robIndex),
		.decode(decode),
		.rfArgA(rfArgA),
		.rfArgB(rfArgB),
		.rfArgT(rfArgT),
		.mulBusy(mulBusy),
		.stage(stage.station)
	);

	aluOperate operate_i (
		.clk(clk),
		.rst(rst),
		.stage(stage.execute),
		.opValid(opValid),
		.opResult(opResult)
	);

	aluMultiplier multiplier_i (
		.clk(clk),
		.rst(rst),
		.stage(stage.execute),
		.mulBusy(mulBusy),
		.mulValid(mulValid),
		.mulResult(mulResult)
	);

	resultMerge merge_i (
		.clk(clk),
		.rst(rst),
		.stage(stage.merge),
		.opValid(opValid),
		.mulValid(mulValid),
		.opResult(opResult),
		.mulResult(mulResult),
		.wbValid(wbValid),
		.wbId(wbId),
		.wbValue(wbValue)
	);

endmodule

//--- verification/aluCluster_assert.sv
// ==========================================================================
// ALU station protocol assertions, bound into every station instance
// ==========================================================================

module aluStationAssert (
	input logic clk,
	input logic rst,
	input logic mulBusy,
	input logic ld,
	input logic scDone,
	input logic startMulti
);

	// A loaded MUL holds off the next accept until the multiplier is busy
	mulLoadOnce: assert property (@(posedge clk) disable iff (rst)
		ld && startMulti |=> !ld)
		else $error("Station loaded again right after a multicycle operation");

	// No accept while the multiplier is still iterating
	busyBlocks: assert property (@(posedge clk) disable iff (rst) mulBusy |=> !ld)
		else $error("Station accepted an instruction while the multiplier was busy");

	// An operation has exactly one completion class
	oneClass: assert property (@(posedge clk) disable iff (rst) !(scDone && startMulti))
		else $error("scDone and startMulti are high together");

	// Starting the multiplier makes the cluster non-idle on the next cycle
	startGoesBusy: assert property (@(posedge clk) disable iff (rst)
		startMulti |=> mulBusy)
		else $error("Multiplier did not go busy after startMulti");

endmodule

bind aluStation aluStationAssert stationAssert_i (
	.clk(clk),
	.rst(rst),
	.mulBusy(mulBusy),
	.ld(stage.ld),
	.scDone(stage.scDone),
	.startMulti(stage.startMulti)
);

//--- verification/aluCluster_tb.sv
// ==========================================================================
// ALU cluster testbench, replays the stimulus file with random gaps and
// checks every writeback for tag, value and latency
// ==========================================================================

`include "aluCluster_macros.svh"

module aluCluster_tb;
	import aluClusterPkg::*;

	// Words per stimulus line and room for the whole file
	localparam int FIELDS = 9;
	localparam int MAX_RECORDS = 64;

	// One writeback the cluster still owes, with the cycle it is due
	typedef struct packed {
		robIndex_t id;
		value_t value;
		int at;
	} expect_t;

	logic clk;
	logic rst;
	logic available;
	logic issue;
	logic robIndexValid;
	robIndex_t robIndex;
	decodeBus_t decode;
	value_t rfArgA;
	value_t rfArgB;
	value_t rfArgT;
	logic idle;
	logic wbValid;
	robIndex_t wbId;
	value_t wbValue;

	value_t stimMem [0:FIELDS*MAX_RECORDS-1];
	expect_t expectQ [$];
	int unsigned lcgState;
	int cycle;
	int watchCycles = 0;
	int cycleLimit = 0;
	// Set for one cycle after a multicycle accept, the station is still loading
	logic pendingMul;
	// Falling-edge cycles during which the running MUL keeps idle low
	int busyFrom;
	int busyTo;
	int indexErrors;
	int valueErrors;
	int timingErrors;
	int otherErrors;

	aluCluster dut_i (
		.clk(clk),
		.rst(rst),
		.available(available),
		.issue(issue),
		.robIndexValid(robIndexValid),
		.robIndex(robIndex),
		.decode(decode),
		.rfArgA(rfArgA),
		.rfArgB(rfArgB),
		.rfArgT(rfArgT),
		.idle(idle),
		.wbValid(wbValid),
		.wbId(wbId),
		.wbValue(wbValue)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#4 clk = ~clk;
		end
	end

	// Run limit, set once the stimulus length is known
	always @(posedge clk) begin
		watchCycles <= watchCycles + 1;
		if (cycleLimit > 0 && watchCycles >= cycleLimit) begin
			$display("Timeout after %0d cycles, %0d writebacks never arrived",
				watchCycles, expectQ.size());
			$display("TEST FAIL");
			$finish;
		end
	end

	// ======================================================================
	// Helpers
	// ======================================================================

	function automatic int unsigned nextRand();
		lcgState = lcgState * 32'd1103515245 + 32'd12345;
		return lcgState >> 16;
	endfunction

	task automatic compareIndex(input string name, input robIndex_t got, input robIndex_t exp);
		if (got !== exp) begin
			indexErrors++;
			$display("CHECK FAILED at %0t: %s got %0d expected %0d", $time, name, got, exp);
		end
	endtask

	task automatic compareValue(input string name, input value_t got, input value_t exp);
		if (got !== exp) begin
			valueErrors++;
			$display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic compareCycle(input string name, input int got, input int exp);
		if (got != exp) begin
			timingErrors++;
			$display("CHECK FAILED at %0t: %s got %0d expected %0d", $time, name, got, exp);
		end
	endtask

	task automatic compareFlag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			otherErrors++;
			$display("CHECK FAILED at %0t: %s got %b expected %b", $time, name, got, exp);
		end
	endtask

	// Advances to the next falling edge and checks any writeback showing there
	task automatic nextCycle();
		expect_t head;
		@(negedge clk);
		cycle++;
		// Idle drops for the 16 iterations of a running MUL and nowhere else
		compareFlag("idle", idle, (cycle < busyFrom) || (cycle > busyTo));
		if (wbValid) begin
			if (expectQ.size() == 0) begin
				otherErrors++;
				$display("Writeback with tag %0d at %0t matches no accepted issue", wbId, $time);
			end else begin
				head = expectQ.pop_front();
				compareIndex("wbId", wbId, head.id);
				compareValue("wbValue", wbValue, head.value);
				compareCycle("wbValid cycle", cycle, head.at);
			end
		end
	endtask

	task automatic idleCycle();
		issue = 1'b0;
		pendingMul = 1'b0;
		nextCycle();
	endtask

	// Presents one stimulus line until the cluster takes it
	task automatic issueRecord(input int rec);
		int base;
		int gap;
		value_t flags;
		logic realMul;
		logic accepted;
		expect_t entry;
		base = rec * FIELDS;
		flags = stimMem[base+1];
		decode.op = aluOp_e'(stimMem[base][2:0]);
		decode.bitwise = flags[16];
		decode.negA = flags[12];
		decode.negB = flags[8];
		decode.useImm = flags[4];
		decode.copyTarget = flags[0];
		decode.predBits = stimMem[base+2][`BYTE_LANES-1:0];
		decode.imm = stimMem[base+3];
		rfArgA = stimMem[base+4];
		rfArgB = stimMem[base+5];
		rfArgT = stimMem[base+6];
		robIndex = stimMem[base+7][`ROB_INDEX_BITS-1:0];
		// A mask keeping every byte turns even a MUL into a two-cycle copy
		realMul = (decode.op == MUL) && !decode.copyTarget && (decode.predBits != '0);
		accepted = 1'b0;
		while (!accepted) begin
			gap = int'(nextRand() % 3);
			repeat (gap) idleCycle();
			issue = 1'b1;
			available = (nextRand() % 4) != 0;
			robIndexValid = (nextRand() % 6) != 0;
			accepted = available && robIndexValid && idle && !pendingMul;
			pendingMul = accepted && realMul;
			if (accepted) begin
				entry.id = robIndex;
				entry.value = stimMem[base+8];
				entry.at = cycle + (realMul ? 19 : 2);
				expectQ.push_back(entry);
				// Busy starts the cycle after ld and lasts one cycle per iteration
				if (realMul) begin
					busyFrom = cycle + 2;
					busyTo = cycle + 17;
				end
			end
			nextCycle();
		end
		issue = 1'b0;
	endtask

	// ======================================================================
	// Main sequence
	// ======================================================================

	initial begin
		int records;
		int total;
		rst = 1'b1;
		available = 1'b0;
		issue = 1'b0;
		robIndexValid = 1'b0;
		robIndex = '0;
		decode = '0;
		rfArgA = '0;
		rfArgB = '0;
		rfArgT = '0;
		lcgState = 32'd98893;
		cycle = 0;
		pendingMul = 1'b0;
		busyFrom = 1;
		busyTo = 0;
		indexErrors = 0;
		valueErrors = 0;
		timingErrors = 0;
		otherErrors = 0;
		$readmemh("verification/aluCluster_stim.txt", stimMem);
		records = 0;
		while (records < MAX_RECORDS && stimMem[records*FIELDS] != 64'hf)
			records++;
		if (records == MAX_RECORDS || records == 0) begin
			otherErrors++;
			$display("Stimulus file has no end marker or no operations");
		end
		cycleLimit = records * 25 + 100;
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		compareFlag("idle", idle, 1'b1);
		compareFlag("wbValid", wbValid, 1'b0);
		for (int rec = 0; rec < records && rec < MAX_RECORDS; rec++)
			issueRecord(rec);
		while (expectQ.size() > 0)
			idleCycle();
		// A few quiet cycles catch a late or duplicated writeback
		repeat (4) idleCycle();
		total = indexErrors + valueErrors + timingErrors + otherErrors;
		$display("Errors: index %0d, value %0d, timing %0d, other %0d",
			indexErrors, valueErrors, timingErrors, otherErrors);
		if (total == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

//--- build.f
+incdir+logic
logic/aluClusterPkg.sv
logic/aluStationIf.sv
logic/aluStation.sv
logic/aluOperate.sv
logic/aluMultiplier.sv
logic/resultMerge.sv
logic/aluCluster.sv
verification/aluCluster_assert.sv
verification/aluCluster_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Compiles the ALU cluster testbench with Verilator and runs it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f build.f --top-module aluCluster_tb -o simv
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/simv)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -q "^TEST PASS$"; then
	exit 0
fi
exit 1

//--- verification/aluCluster_stim.txt
// op flags(bitwise negA negB useImm copyTarget) predBits imm rfArgA rfArgB rfArgT robIndex expected
// op f ends the list
0 00000 ff 0000000000000000 0000000000001234 0000000000000010 1111111111111111 01 0000000000001244
0 00100 ff 0000000000000000 0000000000001234 0000000000000010 1111111111111111 02 0000000000001224
0 01000 ff 0000000000000000 0000000000001234 0000000000000010 1111111111111111 03 ffffffffffffeddc
0 01100 ff 0000000000000000 0000000000001234 0000000000000010 1111111111111111 04 ffffffffffffedbc
0 10100 ff 0000000000000000 0000000000001234 0000000000000010 1111111111111111 05 0000000000001223
0 11100 ff 0000000000000000 0000000000001234 0000000000000010 1111111111111111 06 ffffffffffffedba
1 00000 ff 0000000000000000 0000000000001234 0000000000000010 1111111111111111 07 0000000000000010
1 10100 ff 0000000000000000 0000000000001234 0000000000000010 1111111111111111 08 0000000000001224
1 11000 ff 0000000000000000 0000000000001234 0000000000000010 1111111111111111 09 0000000000000000
1 01000 ff 0000000000000000 0000000000001234 0000000000000010 1111111111111111 0a 0000000000000000
2 00000 ff 0000000000000000 0000000000001234 0000000000000010 1111111111111111 0b 0000000000001234
2 11100 ff 0000000000000000 0000000000001234 0000000000000010 1111111111111111 0c ffffffffffffffef
3 00000 ff 0000000000000000 0000000000001234 0000000000000010 1111111111111111 0d 0000000000001224
3 11000 ff 0000000000000000 0000000000001234 0000000000000010 1111111111111111 0e ffffffffffffeddb
3 00100 ff 0000000000000000 0000000000001234 0000000000000010 1111111111111111 0f ffffffffffffedc4
0 00010 ff 0000000000000100 0000000000001234 0000000000000010 1111111111111111 10 0000000000001334
2 00010 ff 00000000000000ff 0000000000001234 0000000000000010 1111111111111111 11 00000000000012ff
0 00000 0f 0000000000000000 0000000000001234 0000000000000010 1111111111111111 12 1111111100001244
0 00000 a5 0000000000000000 0000000000001234 0000000000000010 1111111111111111 13 0011001111001144
0 00001 ff 0000000000000000 0000000000001234 0000000000000010 0123456789abcdef 14 0123456789abcdef
4 00000 ff 0000000000000000 0000000012345678 0000000000000010 1111111111111111 15 0000000123456780
4 01000 ff 0000000000000000 0000000000000005 0000000000000007 1111111111111111 16 ffffffffffffffdd
4 00000 ff 0000000000000000 0000000100000000 0000000100000000 1111111111111111 17 0000000000000000
4 00000 ff 0000000000000000 123456789abcdef0 0000000000000010 1111111111111111 18 23456789abcdef00
4 00000 0f 0000000000000000 0000000012345678 0000000000000010 1111111111111111 19 1111111123456780
4 00001 ff 0000000000000000 0000000000001234 0000000000000010 0123456789abcdef 1a 0123456789abcdef
4 00000 00 0000000000000000 0000000000001234 0000000000000010 0123456789abcdef 1b 0123456789abcdef
5 00000 ff 0000000000000000 0000000000001234 0000000000000010 1111111111111111 1c 0000000000001234
0 00000 ff 0000000000000000 fffffffffffffff0 0000000000000010 1111111111111111 1d 0000000000000000
f 00000 00 0000000000000000 0000000000000000 0000000000000000 0000000000000000 00 0000000000000000
